// ==== build.f ====
rtl/memPkg.sv
rtl/memIf.sv
rtl/memArbiter.sv
rtl/byteSequencer.sv
rtl/byteRam.sv
rtl/memSubsystem.sv
dv/memSubsystemTb.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - rtl/memPkg.sv
  - rtl/memIf.sv
  - rtl/memArbiter.sv
  - rtl/byteSequencer.sv
  - rtl/byteRam.sv
  - rtl/memSubsystem.sv
  - target: simulation
    files:
      - dv/memSubsystemTb.sv

// ==== dv/memSubsystemTb.sv ====
`timescale 1ns/10ps

module memSubsystemTb;

    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 8;
    localparam int FillCount   = 64;
    localparam int RandomCount = 400;
    localparam int TotalTxns   = FillCount + RandomCount + 8;
    localparam longint TimeoutNs = TotalTxns * 12 * ClkPeriod + ResetCycles * ClkPeriod;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 hold;
    logic                 fetchValid;
    logic [31:0]          fetchAddr;
    logic                 fetchReady;
    logic                 fetchDone;
    logic [31:0]          fetchInst;
    logic                 dataValid;
    memPkg::memOp         dataOp;
    memPkg::accessSize    dataSize;
    logic [31:0]          dataAddr;
    logic [31:0]          dataWdata;
    logic                 dataReady;
    logic                 dataDone;
    logic [31:0]          dataRdata;

    // reference copy of the RAM contents
    logic [7:0] model [0:255];
    bit         holdOn;
    int         errors;
    int         fetchAccepts;
    int         dataAccepts;
    int         fetchDones;
    int         dataDones;

    memSubsystem #(
        .RamAddrBits (8)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .hold       (hold),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .fetchReady (fetchReady),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .dataValid  (dataValid),
        .dataOp     (dataOp),
        .dataSize   (dataSize),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .dataReady  (dataReady),
        .dataDone   (dataDone),
        .dataRdata  (dataRdata)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // done pulses per port, compared with accepted requests at the end
    always @(negedge clk) begin
        if (!rst) begin
            if (fetchDone) begin
                fetchDones++;
            end
            if (dataDone) begin
                dataDones++;
            end
            assert (!(fetchDone && dataDone)) else begin
                errors++;
                $display("both done outputs were high in the same cycle");
            end
        end
    end

    function automatic int sizeBytes(input memPkg::accessSize size);
        case (size)
            memPkg::sizeByte: return 1;
            memPkg::sizeHalf: return 2;
            default:          return 4;
        endcase
    endfunction

    // little-endian, upper lanes left zero
    function automatic logic [31:0] modelRead(input logic [7:0] addr, input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v[8*i +: 8] = model[addr + i];
        end
        return v;
    endfunction

    function automatic bit randomHold();
        return holdOn && ($urandom % 10 == 0);
    endfunction

    task automatic access(input bit isFetch, input bit alsoFetch, input memPkg::memOp op,
                          input memPkg::accessSize size, input logic [7:0] addr,
                          input logic [31:0] wdata);
        int n;
        int i;
        int cyc;
        int holds;
        int latency;
        bit accepted;
        bit seen;
        logic [31:0] expVal;
        logic [31:0] got;
        n = isFetch ? 4 : sizeBytes(size);
        @(posedge clk);
        if (isFetch) begin
            fetchValid <= 1'b1;
            fetchAddr  <= {24'h0, addr};
        end else begin
            dataValid <= 1'b1;
            dataOp    <= op;
            dataSize  <= size;
            dataAddr  <= {24'h0, addr};
            dataWdata <= wdata;
            if (alsoFetch) begin
                fetchValid <= 1'b1;
            end
        end
        hold <= randomHold();
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = isFetch ? (fetchValid && fetchReady) : (dataValid && dataReady);
            if (!accepted) begin
                @(posedge clk);
                hold <= randomHold();
            end
        end
        // only one access in flight, so the expectation is fixed here
        expVal = modelRead(addr, n);
        if (!isFetch && op == memPkg::opStore) begin
            for (i = 0; i < n; i++) begin
                model[addr + i] = wdata[8*i +: 8];
            end
        end
        if (isFetch) begin
            fetchAccepts++;
        end else begin
            dataAccepts++;
        end
        cyc = 0;
        holds = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            if (cyc == 0) begin
                if (isFetch) begin
                    fetchValid <= 1'b0;
                end else begin
                    dataValid <= 1'b0;
                end
            end
            hold <= randomHold();
            @(negedge clk);
            cyc++;
            seen = isFetch ? fetchDone : dataDone;
            if (!seen) begin
                if (hold) begin
                    holds++;
                end
                assert (!fetchReady && !dataReady) else begin
                    errors++;
                    $display("a ready output was high while an access was in flight");
                end
                assert (!(isFetch ? dataDone : fetchDone)) else begin
                    errors++;
                    $display("done pulse appeared on the port without an access");
                end
            end
        end
        assert (!hold) else begin
            errors++;
            $display("done pulse appeared while hold was high");
        end
        // each held cycle stretches the access by one
        latency = ((isFetch || op == memPkg::opLoad) ? n + 2 : n + 1) + holds;
        assert (cyc == latency) else begin
            errors++;
            $display("Fail %s latency expected 0x%h got 0x%h",
                     isFetch ? "fetchDone" : "dataDone", latency, cyc);
        end
        got = isFetch ? fetchInst : dataRdata;
        if (isFetch || op == memPkg::opLoad) begin
            assert (got == expVal) else begin
                errors++;
                $display("Fail %s expected 0x%h got 0x%h",
                         isFetch ? "fetchInst" : "dataRdata", expVal, got);
            end
        end
    endtask

    initial begin
        int k;
        int kind;
        int n;
        logic [7:0] a;
        memPkg::accessSize sz;
        void'($urandom(32'h5010));
        errors = 0;
        fetchAccepts = 0;
        dataAccepts = 0;
        fetchDones = 0;
        dataDones = 0;
        holdOn = 1'b0;
        rst = 1'b1;
        hold = 1'b0;
        fetchValid = 1'b0;
        fetchAddr = '0;
        dataValid = 1'b0;
        dataOp = memPkg::opLoad;
        dataSize = memPkg::sizeWord;
        dataAddr = '0;
        dataWdata = '0;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!fetchDone && !dataDone) else begin
            errors++;
            $display("a done output was high right after reset");
        end
        assert (fetchReady && dataReady) else begin
            errors++;
            $display("a ready output was low right after reset");
        end

        // RAM is undefined until written
        for (k = 0; k < FillCount; k++) begin
            access(0, 0, memPkg::opStore, memPkg::sizeWord, 8'(k * 4), $urandom);
        end

        access(0, 0, memPkg::opStore, memPkg::sizeWord, 8'h40, 32'hA5C3_1E07);
        access(0, 0, memPkg::opLoad,  memPkg::sizeWord, 8'h40, '0);
        access(0, 0, memPkg::opStore, memPkg::sizeByte, 8'h41, 32'h0000_005A);
        access(0, 0, memPkg::opStore, memPkg::sizeHalf, 8'h46, 32'h0000_9C81);
        access(0, 0, memPkg::opLoad,  memPkg::sizeHalf, 8'h40, '0);
        access(1, 0, memPkg::opLoad,  memPkg::sizeWord, 8'h44, '0);

        // both ports ask in the same idle cycle
        @(posedge clk);
        fetchAddr <= 32'h0000_0040;
        access(0, 1, memPkg::opLoad, memPkg::sizeHalf, 8'h80, '0);
        access(1, 0, memPkg::opLoad, memPkg::sizeWord, 8'h40, '0);

        holdOn = 1'b1;
        for (k = 0; k < RandomCount; k++) begin
            kind = $urandom % 3;
            sz = memPkg::accessSize'($urandom % 3);
            n = (kind == 0) ? 4 : sizeBytes(sz);
            a = 8'($urandom % (257 - n));
            if (kind == 0) begin
                access(1, 0, memPkg::opLoad, memPkg::sizeWord, a, '0);
            end else begin
                access(0, 0, (kind == 1) ? memPkg::opLoad : memPkg::opStore, sz, a, $urandom);
            end
        end
        holdOn = 1'b0;
        @(posedge clk);
        hold <= 1'b0;
        @(negedge clk);

        assert (fetchDones == fetchAccepts && dataDones == dataAccepts) else begin
            errors++;
            $display("number of done pulses differs from accepted requests");
        end
        $display("errors: %0d  fetch: %0d accepted %0d done  data: %0d accepted %0d done",
                 errors, fetchAccepts, fetchDones, dataAccepts, dataDones);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(TimeoutNs);
        $display("run timed out before all accesses completed");
        $display("test failed");
        $finish;
    end

endmodule

// ==== rtl/memSubsystem.sv ====
`timescale 1ns/10ps

module memSubsystem #(
    parameter int RamAddrBits = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hold,

    input  logic                          fetchValid,
    input  logic [memPkg::AddrWidth-1:0]  fetchAddr,
    output logic                          fetchReady,
    output logic                          fetchDone,
    output logic [memPkg::DataWidth-1:0]  fetchInst,

    input  logic                          dataValid,
    input  memPkg::memOp                  dataOp,
    input  memPkg::accessSize             dataSize,
    input  logic [memPkg::AddrWidth-1:0]  dataAddr,
    input  logic [memPkg::DataWidth-1:0]  dataWdata,
    output logic                          dataReady,
    output logic                          dataDone,
    output logic [memPkg::DataWidth-1:0]  dataRdata
);
    memReqIf  reqBus ();
    ramPortIf ramBus ();

    memArbiter arbiter (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .fetchReady (fetchReady),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .dataValid  (dataValid),
        .dataOp     (dataOp),
        .dataSize   (dataSize),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .dataReady  (dataReady),
        .dataDone   (dataDone),
        .dataRdata  (dataRdata),
        .req        (reqBus.requester)
    );

    byteSequencer sequencer (
        .clk  (clk),
        .rst  (rst),
        .hold (hold),
        .req  (reqBus.server),
        .ram  (ramBus.master)
    );

    byteRam #(
        .AddrBits (RamAddrBits)
    ) ram (
        .clk  (clk),
        .port (ramBus.slave)
    );

endmodule

// ==== rtl/byteRam.sv ====
`timescale 1ns/10ps

module byteRam #(
    parameter int AddrBits = 8
) (
    input  logic     clk,
    ramPortIf.slave  port
);
    logic [7:0] mem [0:(1 << AddrBits) - 1];
    logic [AddrBits-1:0] index;

    // upper address bits are ignored
    assign index = port.addr[AddrBits-1:0];

    always_ff @(posedge clk) begin
        if (port.en) begin
            if (port.we) begin
                mem[index] <= port.wdata;
            end else begin
                port.rdata <= mem[index];
            end
        end
    end

endmodule

// ==== rtl/byteSequencer.sv ====
`timescale 1ns/10ps

module byteSequencer (
    input  logic      clk,
    input  logic      rst,
    input  logic      hold,
    memReqIf.server   req,
    ramPortIf.master  ram
);
    memPkg::seqState               state;
    memPkg::memOp                  opReg;
    memPkg::accessSize             sizeReg;
    logic [memPkg::AddrWidth-1:0]  baseReg;
    logic [memPkg::DataWidth-1:0]  wdataReg;
    logic [memPkg::DataWidth-1:0]  assembly;
    logic [2:0]                    cnt;
    logic [2:0]                    byteCount;
    logic [1:0]                    laneIn;
    logic                          accept;
    logic                          isLoad;
    logic                          issuing;
    logic                          finalStep;

    always_comb begin
        case (sizeReg)
            memPkg::sizeByte: byteCount = 3'd1;
            memPkg::sizeHalf: byteCount = 3'd2;
            default:          byteCount = 3'd4;
        endcase
    end

    assign accept = req.valid && req.ready;
    assign isLoad = (opReg == memPkg::opLoad);

    // byte arriving now was addressed on the previous step
    assign laneIn = cnt[1:0] - 2'd1;

    assign issuing = (state == memPkg::stAddr) && (cnt != byteCount);

    // loads need one extra step to collect the last byte
    assign finalStep = isLoad ? (cnt == byteCount) : (cnt == byteCount - 3'd1);

    assign req.ready = (state == memPkg::stIdle) && !hold;
    assign req.done  = (state == memPkg::stDone) && !hold;
    assign req.rdata = assembly;

    assign ram.en    = issuing && !hold;
    assign ram.we    = !isLoad;
    assign ram.addr  = baseReg + {{(memPkg::AddrWidth - 3){1'b0}}, cnt};
    assign ram.wdata = wdataReg[8*cnt[1:0] +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::stIdle;
            cnt   <= '0;
        end else if (!hold) begin
            case (state)
                memPkg::stIdle: begin
                    if (accept) begin
                        state <= memPkg::stAddr;
                        cnt   <= '0;
                    end
                end
                memPkg::stAddr: begin
                    cnt <= cnt + 3'd1;
                    if (finalStep) begin
                        state <= memPkg::stDone;
                    end
                end
                memPkg::stDone: state <= memPkg::stIdle;
                default:        state <= memPkg::stIdle;
            endcase
        end
    end

    // request fields and the load word being built
    always_ff @(posedge clk) begin
        if (accept) begin
            opReg    <= req.op;
            sizeReg  <= req.size;
            baseReg  <= req.addr;
            wdataReg <= req.wdata;
            // cleared lanes give the zero extension
            assembly <= '0;
        end else if ((state == memPkg::stAddr) && !hold && isLoad && (cnt != 3'd0)) begin
            assembly[8*laneIn +: 8] <= ram.rdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (state == memPkg::stIdle) |-> !ram.en);

    assert property (@(posedge clk) disable iff (rst)
        (state != memPkg::stIdle) |-> !req.ready);

endmodule

// ==== rtl/memArbiter.sv ====
`timescale 1ns/10ps

module memArbiter (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          fetchValid,
    input  logic [memPkg::AddrWidth-1:0]  fetchAddr,
    output logic                          fetchReady,
    output logic                          fetchDone,
    output logic [memPkg::DataWidth-1:0]  fetchInst,

    input  logic                          dataValid,
    input  memPkg::memOp                  dataOp,
    input  memPkg::accessSize             dataSize,
    input  logic [memPkg::AddrWidth-1:0]  dataAddr,
    input  logic [memPkg::DataWidth-1:0]  dataWdata,
    output logic                          dataReady,
    output logic                          dataDone,
    output logic [memPkg::DataWidth-1:0]  dataRdata,

    memReqIf.requester                    req
);
    memPkg::seqState grantPhase;
    logic            grantData;
    logic            pickData;

    // data port wins when both ask while idle
    assign pickData = (grantPhase == memPkg::stIdle) ? dataValid : grantData;

    assign req.valid = (grantPhase == memPkg::stIdle) && (dataValid || fetchValid);
    // a fetch goes out as a word load
    assign req.op    = pickData ? dataOp : memPkg::opLoad;
    assign req.size  = pickData ? dataSize : memPkg::sizeWord;
    assign req.addr  = pickData ? dataAddr : fetchAddr;
    assign req.wdata = pickData ? dataWdata : '0;

    assign dataReady  = req.ready && (grantPhase == memPkg::stIdle);
    assign fetchReady = req.ready && (grantPhase == memPkg::stIdle) && !dataValid;

    // completions only reach the granted port
    assign dataDone  = req.done && (grantPhase == memPkg::stAddr) && grantData;
    assign fetchDone = req.done && (grantPhase == memPkg::stAddr) && !grantData;
    assign dataRdata = grantData ? req.rdata : '0;
    assign fetchInst = grantData ? '0 : req.rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            grantPhase <= memPkg::stIdle;
            grantData  <= 1'b0;
        end else begin
            case (grantPhase)
                memPkg::stIdle: begin
                    if (req.valid && req.ready) begin
                        grantPhase <= memPkg::stAddr;
                        grantData  <= pickData;
                    end
                end
                memPkg::stAddr: begin
                    if (req.done) begin
                        grantPhase <= memPkg::stIdle;
                    end
                end
                default: grantPhase <= memPkg::stIdle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(fetchDone && dataDone));

    // sequencer completes only an access this arbiter handed over
    assert property (@(posedge clk) disable iff (rst)
        req.done |-> grantPhase == memPkg::stAddr);

endmodule

// ==== rtl/memIf.sv ====
`timescale 1ns/10ps

// one 32-bit access, arbiter towards sequencer
interface memReqIf;
    logic                          valid;
    logic                          ready;
    memPkg::memOp                  op;
    memPkg::accessSize             size;
    logic [memPkg::AddrWidth-1:0]  addr;
    logic [memPkg::DataWidth-1:0]  wdata;
    logic                          done;
    logic [memPkg::DataWidth-1:0]  rdata;

    modport requester (
        output valid, op, size, addr, wdata,
        input  ready, done, rdata
    );

    modport server (
        input  valid, op, size, addr, wdata,
        output ready, done, rdata
    );
endinterface

// byte-wide RAM port
interface ramPortIf;
    logic                          en;
    logic                          we;
    logic [memPkg::AddrWidth-1:0]  addr;
    logic [7:0]                    wdata;
    logic [7:0]                    rdata;

    modport master (
        output en, we, addr, wdata,
        input  rdata
    );

    modport slave (
        input  en, we, addr, wdata,
        output rdata
    );
endinterface

// ==== rtl/memPkg.sv ====
package memPkg;

    // byte address and data word widths
    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;

    typedef enum logic {
        opLoad,
        opStore
    } memOp;

    // number of bytes moved by one access
    typedef enum logic [1:0] {
        sizeByte,
        sizeHalf,
        sizeWord
    } accessSize;

    // stIdle waits for a request, stAddr walks the bytes,
    // stDone presents the completion
    typedef enum logic [1:0] {
        stIdle,
        stAddr,
        stDone
    } seqState;

endpackage
